//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbGteTop
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: build
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -xF "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- gteBusPkg.sv
package gteBusPkg;

	// ----------------------------------------------------------------------
	//   Host side access
	// ----------------------------------------------------------------------
	typedef struct packed {
		gteRegPkg::regId_t id;     // Top bit picks control file
		logic              wr;     // 1 write, 0 read
		logic [31:0]       wdata;  // Ignored on reads
	} hostReq_t;

	// ----------------------------------------------------------------------
	//   Special register readback
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic [2:0][31:0]                 sxy;   // Screen XY FIFO, entry 2 newest
		logic [3:0][15:0]                 sz;    // SZ0..SZ3
		logic [3:0][15:0]                 ir;    // IR0..IR3 raw 16 bit
		logic [2:0][31:0]                 crgb;  // Color FIFO words
		logic [7:0]                       code;  // RGBC code byte
		logic [3*gteRegPkg::COLOR_W-1:0]  orgb;  // Blue, green, red from high to low
		logic [gteRegPkg::LZC_W-1:0]      lzcr;  // Last lead count
	} specRd_t;

endpackage

//--- gteCpuPort.sv
`timescale 1ns/1ps

module gteCpuPort (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_req,
	input  gteBusPkg::hostReq_t  i_hostReq,
	input  logic [31:0]          i_rdata,    // Formatted read word
	output logic                 o_strobe,
	output gteBusPkg::hostReq_t  o_acc,
	output gteRegPkg::regId_t    o_accId,    // ID for the formatter
	output logic                 o_ack,
	output logic [31:0]          o_rdata
);

	// ----------------------------------------------------------------------
	//   Handshake FSM
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		stIdle,      // Waiting for a request
		stAccess,    // Strobe out to files and special registers
		stCapture,   // Read word settles through the formatter
		stRelease    // Ack held until the host drops the request
	} state_t;

	state_t state;
	logic   reqQ;   // Registered request line

	assign o_strobe = (state == stAccess);  // One cycle per handshake

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state   <= stIdle;
			reqQ    <= 1'b0;
			o_ack   <= 1'b0;
			o_rdata <= '0;
		end else begin
			reqQ <= i_req;
			case (state)
			stIdle:    if (reqQ) state <= stAccess;
			stAccess:  state <= stCapture;
			stCapture: begin
				o_rdata <= i_rdata;     // Held until the next handshake
				o_ack   <= 1'b1;
				state   <= stRelease;
			end
			stRelease: if (!reqQ) begin
				o_ack <= 1'b0;
				state <= stIdle;
			end
			default:   state <= stIdle;
			endcase
		end
	end

	// Request latch, the host holds it stable anyway
	always_ff @(posedge i_clk) begin
		if (state == stIdle && reqQ) o_acc <= i_hostReq;
		if (o_strobe) o_accId <= o_acc.id;   // Lines up with file read data
	end

endmodule

//--- gteLeadCount.sv
`timescale 1ns/1ps

module gteLeadCount (
	input  logic [31:0]                  i_value,
	output logic [gteRegPkg::LZC_W-1:0]  o_count
);

	// ----------------------------------------------------------------------
	//   Leading sign bit count
	// ----------------------------------------------------------------------
	// Bit 31 always counts itself, so the result is 1..32
	// Bits below 31 that differ from the sign stop the run

	logic [30:0] diff;  // Set where a bit differs from bit 31
	int          lead;  // Run length of sign copies

	assign diff = i_value[30:0] ^ {31{i_value[31]}};

	always_comb begin
		lead = 32;                     // Whole word equals the sign
		// Lowest first so the highest differing bit wins
		for (int i = 0; i < 31; i++) begin
			if (diff[i]) begin
				lead = 31 - i;
			end
		end
		o_count = lead[gteRegPkg::LZC_W-1:0];
	end

endmodule

//--- gteReadFormat.sv
`timescale 1ns/1ps

module gteReadFormat (
	input  gteRegPkg::regId_t   i_id,
	input  logic [31:0]         i_dataWord,
	input  logic [31:0]         i_ctrlWord,
	input  gteBusPkg::specRd_t  i_spec,
	output logic [31:0]         o_rdata
);

	logic [31:0]       rawWord;  // Selected source before promotion
	logic [1:0]        sel;      // Entry inside a group of IDs
	gteRegPkg::ext_t   extSel;

	assign sel = i_id[1:0];

	// ----------------------------------------------------------------------
	//   Source select
	// ----------------------------------------------------------------------
	always_comb begin
		rawWord = i_dataWord;                   // Plain data register
		if (i_id[gteRegPkg::CTRL_BIT]) begin
			rawWord = i_ctrlWord;               // All control registers stored
		end else begin
			case (i_id)
			gteRegPkg::SXY0,
			gteRegPkg::SXY1,
			gteRegPkg::SXY2: rawWord = i_spec.sxy[sel];
			gteRegPkg::SXYP: rawWord = i_spec.sxy[2];   // Mirror of newest, no pop
			gteRegPkg::SZ0,
			gteRegPkg::SZ1,
			gteRegPkg::SZ2,
			gteRegPkg::SZ3: rawWord = {16'h0000, i_spec.sz[sel]};
			gteRegPkg::IR0,
			gteRegPkg::IR1,
			gteRegPkg::IR2,
			gteRegPkg::IR3: rawWord = {16'h0000, i_spec.ir[sel]};
			gteRegPkg::RGB0,
			gteRegPkg::RGB1,
			gteRegPkg::RGB2: rawWord = i_spec.crgb[sel];
			gteRegPkg::RGBC: begin
				// Code byte from the special copy
				rawWord = {i_spec.code, i_dataWord[23:0]};
			end
			gteRegPkg::IRGB,
			gteRegPkg::ORGB: rawWord = 32'(i_spec.orgb);  // Zero padded
			gteRegPkg::LZCR: rawWord = 32'(i_spec.lzcr);
			default: ;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	//   16 bit promotion
	// ----------------------------------------------------------------------
	assign extSel = gteRegPkg::extClass(i_id);

	always_comb begin
		case (extSel)
		gteRegPkg::EXT_SIGN: o_rdata = {{16{rawWord[15]}}, rawWord[15:0]};
		gteRegPkg::EXT_ZERO: o_rdata = {16'h0000, rawWord[15:0]};
		default:             o_rdata = rawWord;  // Full 32 bit register
		endcase
	end

endmodule

//--- gteRegFile.sv
`timescale 1ns/1ps

module gteRegFile #(
	parameter int ADDR_W = 5,
	parameter int DATA_W = 32
) (
	input  logic              i_clk,
	input  logic              i_wr,
	input  logic              i_rd,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata
);

	// ----------------------------------------------------------------------
	//   Storage
	// ----------------------------------------------------------------------
	logic [DATA_W-1:0] mem [2**ADDR_W];

	// One shared address, a host access is either a read or a write
	always_ff @(posedge i_clk) begin
		if (i_wr) begin
			mem[i_addr] <= i_wdata;     // Visible to reads next cycle
		end
		if (i_rd) begin
			o_rdata <= mem[i_addr];     // Old word on a same cycle write
		end
		// Not enabled so the last read word stays on the output
	end

endmodule

//--- gteRegPkg.sv
package gteRegPkg;

	// ----------------------------------------------------------------------
	//   Sizes
	// ----------------------------------------------------------------------
	localparam int REG_COUNT = 32;                 // Entries per file
	localparam int CTRL_BIT  = $clog2(REG_COUNT);  // ID bit that selects the control file
	localparam int COLOR_W   = 5;                  // Bits per derived color component
	localparam int LZC_W     = 6;                  // Lead count range 1..32

	typedef logic [CTRL_BIT-1:0] regAddr_t;        // Index inside one file
	typedef logic [CTRL_BIT:0]   regId_t;          // Host register ID

	// ----------------------------------------------------------------------
	//   Data register IDs
	// ----------------------------------------------------------------------
	localparam regId_t VZ0  = 6'd1;
	localparam regId_t VZ1  = 6'd3;
	localparam regId_t VZ2  = 6'd5;
	localparam regId_t RGBC = 6'd6;   // Code byte in bits 31..24
	localparam regId_t OTZ  = 6'd7;
	localparam regId_t IR0  = 6'd8;
	localparam regId_t IR1  = 6'd9;
	localparam regId_t IR2  = 6'd10;
	localparam regId_t IR3  = 6'd11;
	localparam regId_t SXY0 = 6'd12;
	localparam regId_t SXY1 = 6'd13;
	localparam regId_t SXY2 = 6'd14;
	localparam regId_t SXYP = 6'd15;  // FIFO push
	localparam regId_t SZ0  = 6'd16;
	localparam regId_t SZ1  = 6'd17;
	localparam regId_t SZ2  = 6'd18;
	localparam regId_t SZ3  = 6'd19;
	localparam regId_t RGB0 = 6'd20;
	localparam regId_t RGB1 = 6'd21;
	localparam regId_t RGB2 = 6'd22;
	localparam regId_t IRGB = 6'd28;  // Reads as ORGB
	localparam regId_t ORGB = 6'd29;
	localparam regId_t LZCS = 6'd30;
	localparam regId_t LZCR = 6'd31;

	// Control file indexes
	localparam regAddr_t R33  = 5'd4;
	localparam regAddr_t L33  = 5'd12;
	localparam regAddr_t LB3  = 5'd20;
	localparam regAddr_t H    = 5'd26;  // First of the zero range
	localparam regAddr_t ZSF4 = 5'd30;  // Last of the zero range

	// ----------------------------------------------------------------------
	//   Read promotion classes
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {EXT_NONE, EXT_SIGN, EXT_ZERO} ext_t;

	function automatic ext_t extClass(input regId_t id);
		regAddr_t idx;
		ext_t     cls;
		idx = id[CTRL_BIT-1:0];
		cls = EXT_NONE;
		if (id[CTRL_BIT]) begin
			if (idx == R33 || idx == L33 || idx == LB3) cls = EXT_SIGN;
			else if (idx >= H && idx <= ZSF4)          cls = EXT_ZERO;
		end else begin
			if (id == VZ0 || id == VZ1 || id == VZ2)    cls = EXT_SIGN;
			else if (id >= IR0 && id <= IR3)           cls = EXT_SIGN;
			else if (id == OTZ)                        cls = EXT_ZERO;
			else if (id >= SZ0 && id <= SZ3)           cls = EXT_ZERO;
		end
		return cls;
	endfunction

endpackage

//--- gteSpecialRegs.sv
`timescale 1ns/1ps

module gteSpecialRegs (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_strobe,
	input  gteBusPkg::hostReq_t  i_acc,
	output gteBusPkg::specRd_t   o_spec
);

	// ----------------------------------------------------------------------
	//   Registers outside the files
	// ----------------------------------------------------------------------
	logic [2:0][31:0]             sxyQ;   // Screen XY FIFO
	logic [3:0][15:0]             szQ;
	logic [3:0][15:0]             irQ;
	logic [2:0][31:0]             crgbQ;  // Color FIFO
	logic [7:0]                   codeQ;  // RGBC code byte
	logic [gteRegPkg::LZC_W-1:0]  lzcrQ;

	logic [gteRegPkg::LZC_W-1:0]  leadCount;  // Count of the write data
	logic                         dataWr;     // Host write into data ID space
	logic [1:0]                   sel;        // Entry inside a group of IDs

	assign dataWr = i_strobe & i_acc.wr & ~i_acc.id[gteRegPkg::CTRL_BIT];
	assign sel    = i_acc.id[1:0];  // Groups start on a multiple of four

	gteLeadCount i_leadCount (
		.i_value (i_acc.wdata),
		.o_count (leadCount)
	);

	// ----------------------------------------------------------------------
	//   Write decode
	// ----------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sxyQ  <= '0;
			szQ   <= '0;
			irQ   <= '0;
			crgbQ <= '0;
			codeQ <= '0;
			lzcrQ <= '0;
		end else if (dataWr) begin
			case (i_acc.id)
			gteRegPkg::SXY0,
			gteRegPkg::SXY1,
			gteRegPkg::SXY2: begin
				sxyQ[sel] <= i_acc.wdata;   // Direct load, no shift
			end
			gteRegPkg::SXYP: begin
				// Push, oldest entry drops out
				sxyQ[0] <= sxyQ[1];
				sxyQ[1] <= sxyQ[2];
				sxyQ[2] <= i_acc.wdata;
			end
			gteRegPkg::SZ0,
			gteRegPkg::SZ1,
			gteRegPkg::SZ2,
			gteRegPkg::SZ3: begin
				szQ[sel] <= i_acc.wdata[15:0];
			end
			gteRegPkg::IR0,
			gteRegPkg::IR1,
			gteRegPkg::IR2,
			gteRegPkg::IR3: begin
				irQ[sel] <= i_acc.wdata[15:0];  // Sign added on read
			end
			gteRegPkg::RGB0,
			gteRegPkg::RGB1,
			gteRegPkg::RGB2: begin
				crgbQ[sel] <= i_acc.wdata;
			end
			gteRegPkg::RGBC: codeQ <= i_acc.wdata[31:24];
			gteRegPkg::LZCS: lzcrQ <= leadCount;     // Result readable at LZCR
			default: ;                               // Plain register, files only
			endcase
		end
	end

	// ----------------------------------------------------------------------
	//   IR to 5 bit color
	// ----------------------------------------------------------------------
	function automatic logic [gteRegPkg::COLOR_W-1:0] toColor(input logic [15:0] ir);
		if (ir[15]) begin
			return '0;              // Negative clips to zero
		end
		if (|ir[14:12]) begin
			return '1;              // Too large saturates
		end
		return ir[11:7];
	endfunction

	always_comb begin
		o_spec.sxy  = sxyQ;
		o_spec.sz   = szQ;
		o_spec.ir   = irQ;
		o_spec.crgb = crgbQ;
		o_spec.code = codeQ;
		o_spec.orgb = {toColor(irQ[3]), toColor(irQ[2]), toColor(irQ[1])}; // B G R
		o_spec.lzcr = lzcrQ;
	end

endmodule

//--- gteTop.sv
`timescale 1ns/1ps

module gteTop #(
	parameter int ADDR_W = 5,
	parameter int DATA_W = 32
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_req,
	input  gteBusPkg::hostReq_t  i_hostReq,
	output logic                 o_ack,
	output logic [31:0]          o_rdata
);

	// ----------------------------------------------------------------------
	//   Internal wiring
	// ----------------------------------------------------------------------
	logic                 strobe;    // One access per handshake
	gteBusPkg::hostReq_t  acc;       // Latched request
	gteRegPkg::regId_t    accId;     // Delayed ID for the read path
	logic [DATA_W-1:0]    dataWord;
	logic [DATA_W-1:0]    ctrlWord;
	gteBusPkg::specRd_t   spec;
	logic [31:0]          fmtWord;   // Promoted read word

	gteCpuPort i_cpuPort (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_req     (i_req),
		.i_hostReq (i_hostReq),
		.i_rdata   (fmtWord),
		.o_strobe  (strobe),
		.o_acc     (acc),
		.o_accId   (accId),
		.o_ack     (o_ack),
		.o_rdata   (o_rdata)
	);

	// Data file, also keeps writes to special IDs
	gteRegFile #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_dataFile (
		.i_clk   (i_clk),
		.i_wr    (strobe & acc.wr & ~acc.id[gteRegPkg::CTRL_BIT]),
		.i_rd    (strobe & ~acc.id[gteRegPkg::CTRL_BIT]),
		.i_addr  (acc.id[ADDR_W-1:0]),
		.i_wdata (acc.wdata[DATA_W-1:0]),
		.o_rdata (dataWord)
	);

	gteRegFile #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_ctrlFile (
		.i_clk   (i_clk),
		.i_wr    (strobe & acc.wr & acc.id[gteRegPkg::CTRL_BIT]),
		.i_rd    (strobe & acc.id[gteRegPkg::CTRL_BIT]),
		.i_addr  (acc.id[ADDR_W-1:0]),
		.i_wdata (acc.wdata[DATA_W-1:0]),
		.o_rdata (ctrlWord)
	);

	gteSpecialRegs i_specialRegs (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_strobe (strobe),
		.i_acc    (acc),
		.o_spec   (spec)
	);

	gteReadFormat i_readFormat (
		.i_id       (accId),
		.i_dataWord (dataWord),
		.i_ctrlWord (ctrlWord),
		.i_spec     (spec),
		.o_rdata    (fmtWord)
	);

endmodule

//--- sources.f
gteRegPkg.sv
gteBusPkg.sv
gteRegFile.sv
gteLeadCount.sv
gteSpecialRegs.sv
gteReadFormat.sv
gteCpuPort.sv
gteTop.sv
tbGteTop_asserts.sv
tbGteTop.sv

//--- tbGteTop.sv
`timescale 1ns/1ps

module tbGteTop;

	localparam int CLK_HALF   = 4;    // 8 ns period
	localparam int RESET_CYC  = 5;
	localparam int ACK_LIMIT  = 20;   // Edges before a wait gives up
	localparam int RISE_EDGES = 5;    // Drive edge to the edge that sees o_ack high
	localparam int FALL_EDGES = 3;    // i_req low to the edge that sees o_ack low

	typedef struct packed {
		logic        wr;
		logic [5:0]  id;
		logic [31:0] expWord;   // Only meaningful for reads
	} pending_t;

	logic                 i_clk;
	logic                 i_rst;
	logic                 i_req;
	gteBusPkg::hostReq_t  i_hostReq;
	logic                 o_ack;
	logic [31:0]          o_rdata;

	// Shadow state of the register block
	logic [31:0] dataShadow [32];
	logic [31:0] ctrlShadow [32];
	logic [31:0] sxyShadow  [3];
	logic [31:0] crgbShadow [3];
	logic [15:0] szShadow   [4];
	logic [15:0] irShadow   [4];
	logic [5:0]  lzcrShadow;

	pending_t    pendQ [$];           // Accesses waiting for their ack
	logic [31:0] lfsr = 32'h5e29;
	logic        ackSeen = 1'b0;
	int          readsChecked = 0;
	int          valueErrors = 0;
	int          handshakeErrors = 0;
	int          timeouts = 0;

	gteTop i_gteTop (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_req     (i_req),
		.i_hostReq (i_hostReq),
		.o_ack     (o_ack),
		.o_rdata   (o_rdata)
	);

	initial begin
		i_clk = 1'b0;
		forever begin
			#(CLK_HALF) i_clk = ~i_clk;
		end
	end

	// ----------------------------------------------------------------------
	//   Random bits and reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
	endfunction

	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v    = {v[30:0], lfsr[0]};   // One step per bit
		end
	endtask

	function automatic logic [4:0] colorOf(input logic [15:0] ir);
		if (ir[15]) return 5'd0;              // Negative
		if (ir >= 16'h1000) return 5'd31;     // 4096 and up saturates
		return ir[11:7];
	endfunction

	function automatic logic [5:0] leadBits(input logic [31:0] v);
		logic [5:0] n;
		n = 6'd1;                             // Sign bit counts itself
		for (int b = 30; b >= 0 && v[b] == v[31]; b--) begin
			n = n + 6'd1;
		end
		return n;
	endfunction

	function automatic logic [31:0] promote(input logic [5:0] id, input logic [31:0] w);
		logic sx;
		logic zx;
		if (id[5]) begin
			sx = (id[4:0] == 5'd4 || id[4:0] == 5'd12 || id[4:0] == 5'd20);  // R33 L33 LB3
			zx = (id[4:0] >= 5'd26 && id[4:0] <= 5'd30);                      // H to ZSF4
		end else begin
			sx = (id == 6'd1 || id == 6'd3 || id == 6'd5 || (id >= 6'd8 && id <= 6'd11));
			zx = (id == 6'd7 || (id >= 6'd16 && id <= 6'd19));               // OTZ, SZ
		end
		if (sx) return {{16{w[15]}}, w[15:0]};
		if (zx) return {16'h0000, w[15:0]};
		return w;
	endfunction

	function automatic logic [31:0] expectedRead(input logic [5:0] id);
		logic [31:0] raw;
		logic [1:0]  k;
		k   = id[1:0];                        // Entry inside a group
		raw = dataShadow[id[4:0]];
		if (id[5]) raw = ctrlShadow[id[4:0]];
		else if (id >= 6'd12 && id <= 6'd14) raw = sxyShadow[k];
		else if (id == 6'd15) raw = sxyShadow[2];   // SXYP shows the newest
		else if (id >= 6'd16 && id <= 6'd19) raw = {16'h0000, szShadow[k]};
		else if (id >= 6'd8 && id <= 6'd11) raw = {16'h0000, irShadow[k]};
		else if (id >= 6'd20 && id <= 6'd22) raw = crgbShadow[k];
		else if (id == 6'd28 || id == 6'd29)
			raw = {17'h0, colorOf(irShadow[3]), colorOf(irShadow[2]), colorOf(irShadow[1])};
		else if (id == 6'd31) raw = {26'h0, lzcrShadow};
		return promote(id, raw);
	endfunction

	task automatic modelWrite(input logic [5:0] id, input logic [31:0] w);
		logic [1:0] k;
		k = id[1:0];
		if (id[5]) begin
			ctrlShadow[id[4:0]] = w;
		end else begin
			dataShadow[id[4:0]] = w;          // Special IDs land in the file too
			if (id >= 6'd12 && id <= 6'd14) sxyShadow[k] = w;
			else if (id == 6'd15) begin
				sxyShadow[0] = sxyShadow[1];  // Oldest drops out
				sxyShadow[1] = sxyShadow[2];
				sxyShadow[2] = w;
			end
			else if (id >= 6'd16 && id <= 6'd19) szShadow[k] = w[15:0];
			else if (id >= 6'd8 && id <= 6'd11) irShadow[k] = w[15:0];
			else if (id >= 6'd20 && id <= 6'd22) crgbShadow[k] = w;
			else if (id == 6'd30) lzcrShadow = leadBits(w);
		end
	endtask

	// ----------------------------------------------------------------------
	//   Host side handshake
	// ----------------------------------------------------------------------
	task automatic finishRun();
		int assertFails;
		assertFails = i_gteTop.i_cpuPort.i_handshakeAsserts.failCount;
		$display("Reads checked %0d, value errors %0d, handshake errors %0d, timeouts %0d, %s %0d",
			readsChecked, valueErrors, handshakeErrors, timeouts, "assertion failures",
			assertFails);
		if (valueErrors + handshakeErrors + timeouts + assertFails == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	task automatic waitAck(input logic level, output int edges);
		edges = 0;
		do begin
			@(posedge i_clk);
			edges++;
			if (o_ack !== level && edges >= ACK_LIMIT) begin
				$display("Timeout: o_ack did not go to %0b within %0d clock edges", level, ACK_LIMIT);
				timeouts++;
				finishRun();
			end
		end while (o_ack !== level);
	endtask

	task automatic hostAccess(input logic [5:0] id, input logic wr, input logic [31:0] wdata);
		pending_t             p;
		gteBusPkg::hostReq_t  req;
		int                   edges;
		p.wr      = wr;
		p.id      = id;
		p.expWord = wr ? 32'h0 : expectedRead(id);
		req.id    = id;
		req.wr    = wr;
		req.wdata = wdata;
		pendQ.push_back(p);
		i_hostReq <= req;                     // Held until the next access
		i_req     <= 1'b1;
		waitAck(1'b1, edges);
		if (edges != RISE_EDGES) begin
			$display("CHECK FAILED o_ack rise: got 0x%0h edges, expected 0x%0h", edges, RISE_EDGES);
			handshakeErrors++;
		end
		i_req <= 1'b0;
		waitAck(1'b0, edges);
		if (edges != FALL_EDGES) begin
			$display("CHECK FAILED o_ack fall: got 0x%0h edges, expected 0x%0h", edges, FALL_EDGES);
			handshakeErrors++;
		end
		if (wr) modelWrite(id, wdata);
	endtask

	// Compare on the first edge that sees o_ack high
	always @(posedge i_clk) begin : compareRead
		pending_t p;
		if (o_ack && !ackSeen) begin
			if (pendQ.size() == 0) begin
				$display("o_ack rose while no access was outstanding");
				handshakeErrors++;
			end else begin
				p = pendQ.pop_front();
				if (!p.wr) begin
					readsChecked++;
					if (o_rdata !== p.expWord) begin
						$display("CHECK FAILED o_rdata id 0x%02h: got 0x%08h, expected 0x%08h",
							p.id, o_rdata, p.expWord);
						valueErrors++;
					end
				end
			end
		end
		ackSeen = o_ack;
	end

	// ----------------------------------------------------------------------
	//   Stimulus
	// ----------------------------------------------------------------------
	initial begin : stimulus
		logic [31:0] w;
		logic [31:0] idBits;
		logic [15:0] irSet [12];
		logic [31:0] lzcEdge [6];
		i_rst      <= 1'b1;
		i_req      <= 1'b0;
		i_hostReq  <= '0;
		sxyShadow  = '{default: '0};          // Special registers reset to zero
		crgbShadow = '{default: '0};
		szShadow   = '{default: '0};
		irShadow   = '{default: '0};
		lzcrShadow = '0;
		irSet   = '{16'h8000, 16'h1000, 16'h0f80, 16'hffff, 16'h7fff, 16'h0080,
		            16'h0fff, 16'h0000, 16'h1fff, 16'h0c35, 16'hc000, 16'h0100};
		lzcEdge = '{32'h0, 32'hffffffff, 32'h1, 32'h80000000, 32'h00010000, 32'h7fffffff};
		repeat (RESET_CYC) @(posedge i_clk);
		i_rst <= 1'b0;
		if (o_ack !== 1'b0) begin
			$display("CHECK FAILED o_ack after reset: got 0x%0h, expected 0x0", o_ack);
			handshakeErrors++;
		end
		for (int id = 0; id < 64; id++) begin   // Known word in every entry
			randBits(32, w);
			hostAccess(6'(id), 1'b1, w);
		end
		for (int n = 0; n < 100; n++) begin     // Write then read back
			randBits(6, idBits);
			randBits(32, w);
			hostAccess(idBits[5:0], 1'b1, w);
			hostAccess(idBits[5:0], 1'b0, 32'h0);
		end
		for (int n = 0; n < 3; n++) begin       // SXYP pushes
			randBits(32, w);
			hostAccess(6'd15, 1'b1, w);
		end
		for (int id = 12; id <= 15; id++) hostAccess(6'(id), 1'b0, 32'h0);
		for (int s = 0; s < 4; s++) begin       // Color rule on IR1..IR3
			for (int c = 0; c < 3; c++) hostAccess(6'(9 + c), 1'b1, {16'h5a5a, irSet[3*s + c]});
			for (int id = 8; id <= 11; id++) hostAccess(6'(id), 1'b0, 32'h0);
			hostAccess(6'd28, 1'b0, 32'h0);
			hostAccess(6'd29, 1'b0, 32'h0);
		end
		for (int n = 0; n < 10; n++) begin      // Lead count, edges then random
			if (n < 6) w = lzcEdge[n];
			else randBits(32, w);
			hostAccess(6'd30, 1'b1, w);
			hostAccess(6'd31, 1'b0, 32'h0);
		end
		for (int id = 16; id <= 22; id++) begin // SZ and CRGB direct loads
			randBits(32, w);
			hostAccess(6'(id), 1'b1, w);
		end
		for (int id = 0; id < 64; id++) hostAccess(6'(id), 1'b0, 32'h0);
		finishRun();
	end

endmodule

//--- tbGteTop_asserts.sv
`timescale 1ns/1ps

module handshakeAsserts (
	input logic        i_clk,
	input logic        i_rst,
	input logic        i_req,
	input logic        i_strobe,
	input logic        i_ack,
	input logic [31:0] i_rdata
);

	int         failCount = 0;   // Failed assertions so far
	logic       ackQ;
	logic [1:0] strobeCount;     // Strobes since o_ack last fell

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			ackQ        <= 1'b0;
			strobeCount <= '0;
		end else begin
			ackQ <= i_ack;
			if (i_strobe && strobeCount != 2'b11) strobeCount <= strobeCount + 2'd1;
			else if (ackQ && !i_ack) strobeCount <= '0;   // Handshake closed
		end
	end

	// ----------------------------------------------------------------------
	//   Handshake properties
	// ----------------------------------------------------------------------
	a_idleNoAck: assert property (@(posedge i_clk) disable iff (i_rst)
		(!i_req && !i_ack) |=> !i_ack)
		else begin $error("o_ack rose without a request"); failCount++; end

	a_ackHeld: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_ack && i_req) |=> i_ack)
		else begin $error("o_ack dropped while i_req was high"); failCount++; end

	a_oneStrobe: assert property (@(posedge i_clk) disable iff (i_rst)
		i_strobe |-> strobeCount == 2'd0)
		else begin $error("second strobe in one handshake"); failCount++; end

	a_strobeBeforeAck: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_ack) |-> strobeCount == 2'd1)
		else begin $error("o_ack rose without exactly one strobe"); failCount++; end

	a_rdataStable: assert property (@(posedge i_clk) disable iff (i_rst)
		i_ack |=> (!i_ack || $stable(i_rdata)))
		else begin $error("o_rdata changed while o_ack was high"); failCount++; end

endmodule

bind gteCpuPort handshakeAsserts i_handshakeAsserts (
	.i_clk    (i_clk),
	.i_rst    (i_rst),
	.i_req    (i_req),
	.i_strobe (o_strobe),
	.i_ack    (o_ack),
	.i_rdata  (o_rdata)
);
